// File: rv_core.f
src/rv_core_pkg.sv
src/instr_mem.sv
src/reg_file.sv
src/alu.sv
src/core_ctrl.sv
src/rv_core.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  # package first, then the RTL
  - src/rv_core_pkg.sv
  - src/instr_mem.sv
  - src/reg_file.sv
  - src/alu.sv
  - src/core_ctrl.sv
  - src/rv_core.sv
  # testbench sources
  - target: test
    files:
      - test/rv_core_assert.sv
      - test/rv_core_tb.sv

// File: test/rv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic done;
	logic prog_we;
	rv_core_pkg::pc_t prog_addr;
	rv_core_pkg::word_t prog_data;
	rv_core_pkg::reg_idx_t dbg_addr;
	rv_core_pkg::word_t dbg_data;
	rv_core_pkg::pc_t pc;

	integer seed = 16951;
	string test_name = "setup";
	int checks = 0;
	int errors = 0;
	int test_errors = 0;
	int total_instr = 0;
	logic built = 1'b0;
	// reference register array
	rv_core_pkg::word_t model_regs [32];
	// one program per test, each ends in a zero word
	rv_core_pkg::word_t prog_imm [$];
	rv_core_pkg::word_t prog_reg [$];
	rv_core_pkg::word_t prog_shift [$];
	rv_core_pkg::word_t prog_skip [$];
	rv_core_pkg::word_t cur_prog [$];

	rv_core i_rv_core (.*);

	// 40 ns period
	always #20 clk = ~clk;

	// --------------------------------------------------
	// instruction encoding
	// --------------------------------------------------
	function automatic rv_core_pkg::word_t enc_r(input logic [6:0] f7, input int rs2,
		input int rs1, input logic [2:0] f3, input int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_core_pkg::OPC_OP};
	endfunction

	function automatic rv_core_pkg::word_t enc_i(input logic [6:0] opc, input logic [11:0] imm,
		input int rs1, input logic [2:0] f3, input int rd);
		return {imm, rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic logic [11:0] rand_imm();
		integer r;
		r = $random(seed);
		return r[11:0];
	endfunction

	// --------------------------------------------------
	// reference model, straight from the rv32i rules
	// --------------------------------------------------
	function automatic rv_core_pkg::word_t model_alu(input logic [2:0] f3, input logic alt,
		input rv_core_pkg::word_t a, input rv_core_pkg::word_t b);
		rv_core_pkg::word_t y;
		logic signed [31:0] sa;
		sa = a;
		case (f3)
			3'b000: y = alt ? a - b : a + b;
			3'b001: y = a << b[4:0];
			3'b010: y = {31'd0, $signed(a) < $signed(b)};
			3'b011: y = {31'd0, a < b};
			3'b100: y = a ^ b;
			3'b101:
			begin
				// arithmetic shift works on the signed copy
				if (alt)
					y = sa >>> b[4:0];
				else
					y = a >> b[4:0];
			end
			3'b110: y = a | b;
			default: y = a & b;
		endcase
		return y;
	endfunction

	function automatic void model_execute(input rv_core_pkg::word_t w);
		rv_core_pkg::word_t b;
		logic alt;
		if (w[6:0] == rv_core_pkg::OPC_OP)
		begin
			b = model_regs[w[24:20]];
			alt = w[30];
		end
		else if (w[6:0] == rv_core_pkg::OPC_OP_IMM)
		begin
			b = {{20{w[31]}}, w[31:20]};
			// only srai reads bit 30 of the immediate
			alt = (w[14:12] == 3'b101) && w[30];
		end
		else
			return;
		if (w[11:7] != 5'd0)
			model_regs[w[11:7]] = model_alu(w[14:12], alt, model_regs[w[19:15]], b);
	endfunction

	// --------------------------------------------------
	// programs
	// --------------------------------------------------
	function automatic void imm_arith_program();
		logic [2:0] f3 [6] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
		logic [11:0] imm;
		for (int r = 1; r <= 12; r++)
		begin
			imm = rand_imm();
			// odd steps negative
			if (r % 2 == 1)
				imm[11] = 1'b1;
			prog_imm.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, imm, r - 1, f3[(r - 1) % 6], r));
		end
		prog_imm.push_back('0);
	endfunction

	function automatic void reg_ops_program();
		logic [11:0] imm;
		// x1 positive and at least 16, x2 negative, x3 one, x4 random and odd
		imm = rand_imm();
		prog_reg.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, {1'b0, imm[10:0]} | 12'h010, 0, 0, 1));
		imm = rand_imm();
		prog_reg.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, {1'b1, imm[10:0]}, 0, 3'b000, 2));
		prog_reg.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 12'd1, 0, 3'b000, 3));
		prog_reg.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, rand_imm() | 12'h001, 0, 3'b000, 4));
		prog_reg.push_back(enc_r(7'b0000000, 2, 1, 3'b000, 5));
		// 1 minus x1 wraps below zero
		prog_reg.push_back(enc_r(7'b0100000, 1, 3, 3'b000, 6));
		prog_reg.push_back(enc_r(7'b0000000, 4, 1, 3'b001, 7));
		// signed and unsigned compares both ways
		prog_reg.push_back(enc_r(7'b0000000, 1, 2, 3'b010, 8));
		prog_reg.push_back(enc_r(7'b0000000, 2, 1, 3'b010, 9));
		prog_reg.push_back(enc_r(7'b0000000, 1, 2, 3'b011, 10));
		prog_reg.push_back(enc_r(7'b0000000, 2, 1, 3'b011, 11));
		prog_reg.push_back(enc_r(7'b0000000, 2, 1, 3'b100, 12));
		prog_reg.push_back(enc_r(7'b0000000, 4, 2, 3'b101, 13));
		// sra of a negative value
		prog_reg.push_back(enc_r(7'b0100000, 4, 2, 3'b101, 14));
		prog_reg.push_back(enc_r(7'b0000000, 2, 1, 3'b110, 15));
		prog_reg.push_back(enc_r(7'b0000000, 4, 2, 3'b111, 16));
		prog_reg.push_back('0);
	endfunction

	function automatic void shift_imm_program();
		logic [4:0] amt [5];
		logic [11:0] imm;
		imm = rand_imm();
		prog_shift.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, {1'b1, imm[10:0]}, 0, 3'b000, 1));
		imm = rand_imm();
		prog_shift.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, {1'b0, imm[10:0]}, 0, 3'b000, 2));
		amt[0] = 5'd0;
		amt[1] = 5'd1;
		amt[2] = 5'd31;
		imm = rand_imm();
		amt[3] = imm[4:0];
		imm = rand_imm();
		amt[4] = imm[4:0];
		for (int k = 0; k < 5; k++)
		begin
			// slli on the positive value, srli and srai on the negative one
			prog_shift.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, {7'b0000000, amt[k]},
				2, 3'b001, 3 + 3 * k));
			prog_shift.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, {7'b0000000, amt[k]},
				1, 3'b101, 4 + 3 * k));
			prog_shift.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, {7'b0100000, amt[k]},
				1, 3'b101, 5 + 3 * k));
		end
		prog_shift.push_back('0);
	endfunction

	function automatic void zero_reg_program();
		logic [11:0] imm;
		// x1 nonzero
		imm = rand_imm() | 12'h001;
		prog_skip.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, imm, 0, 3'b000, 1));
		// both target x0
		prog_skip.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, imm, 0, 3'b000, 0));
		prog_skip.push_back(enc_r(7'b0000000, 1, 1, 3'b000, 0));
		// load word and lui, neither is supported
		// rs1 field of both is x1, so a stray write would be nonzero
		prog_skip.push_back(enc_i(7'b0000011, 12'h004, 1, 3'b010, 2));
		prog_skip.push_back({20'habc0d, 5'd3, 7'b0110111});
		// x0 still reads zero as a source
		prog_skip.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 12'd1, 0, 3'b000, 4));
		prog_skip.push_back('0);
	endfunction

	// --------------------------------------------------
	// drivers and checks
	// --------------------------------------------------
	task automatic reset_core();
		@(posedge clk);
		rst <= 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
	endtask

	task automatic check_value(input string what, input rv_core_pkg::word_t exp,
		input rv_core_pkg::word_t act);
		checks++;
		assert (act === exp)
		else
		begin
			$display("Error %s %s expected %h actual %h", test_name, what, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic read_reg(input int idx, output rv_core_pkg::word_t val);
		@(posedge clk);
		dbg_addr <= rv_core_pkg::reg_idx_t'(idx);
		// debug read is combinational
		@(negedge clk);
		val = dbg_data;
	endtask

	task automatic compare_regs();
		rv_core_pkg::word_t got;
		for (int i = 0; i < 32; i++)
		begin
			read_reg(i, got);
			check_value($sformatf("x%0d", i), model_regs[i], got);
		end
		$display("%s finished with %0d errors", test_name, test_errors);
	endtask

	task automatic run_program(input string name);
		int halt_idx;
		test_name = name;
		test_errors = 0;
		reset_core();
		foreach (cur_prog[k])
		begin
			@(posedge clk);
			prog_we <= 1'b1;
			prog_addr <= rv_core_pkg::pc_t'(k);
			prog_data <= cur_prog[k];
		end
		@(posedge clk);
		prog_we <= 1'b0;
		// model runs up to the zero word
		foreach (model_regs[i])
			model_regs[i] = '0;
		halt_idx = 0;
		while (cur_prog[halt_idx] != '0)
		begin
			model_execute(cur_prog[halt_idx]);
			halt_idx++;
		end
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		do
			@(negedge clk);
		while (done !== 1'b1);
		// core stops on the zero word
		check_value("pc", rv_core_pkg::word_t'(halt_idx), rv_core_pkg::word_t'(pc));
		compare_regs();
	endtask

	// --------------------------------------------------
	// watchdog, twice the nominal run time plus 2 us
	// --------------------------------------------------
	initial
	begin
		wait (built);
		#(2 * total_instr * 6 * 40 + 2000);
		$display("run did not finish in time, stuck in test %s", test_name);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		rst = 1'b0;
		start = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		dbg_addr = '0;
		imm_arith_program();
		reg_ops_program();
		shift_imm_program();
		zero_reg_program();
		total_instr = prog_imm.size() + prog_reg.size() + prog_shift.size() + prog_skip.size();
		built = 1'b1;

		// reset state, no program
		test_name = "reset state";
		reset_core();
		@(negedge clk);
		check_value("done", 32'd0, {31'd0, done});
		check_value("pc", 32'd0, rv_core_pkg::word_t'(pc));
		foreach (model_regs[i])
			model_regs[i] = '0;
		compare_regs();

		cur_prog = prog_imm;
		run_program("immediate arithmetic");
		cur_prog = prog_reg;
		run_program("register operations");
		cur_prog = prog_shift;
		run_program("shift immediates");
		cur_prog = prog_skip;
		run_program("zero register and skipped opcodes");

		// bound property failures count as errors too
		errors += i_rv_core.i_rv_core_assert.assert_fails;
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
			i_rv_core.i_rv_core_assert.assert_fails);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/rv_core_assert.sv
`timescale 1ns/1ns
`default_nettype none

// handshake and debug port properties of rv_core
module rv_core_assert (
	input wire logic clk,
	input wire logic rst,
	input wire logic done,
	input rv_core_pkg::pc_t pc,
	input rv_core_pkg::reg_idx_t dbg_addr,
	input rv_core_pkg::word_t dbg_data
);

	// failure count, summed into the testbench totals
	int unsigned assert_fails = 0;

	// done is sticky until reset
	done_sticky: assert property (@(posedge clk) disable iff (!rst) done |=> done)
	else
	begin
		$error("done fell while reset was inactive");
		assert_fails++;
	end

	// halted core holds its pc
	pc_held: assert property (@(posedge clk) disable iff (!rst) done |=> $stable(pc))
	else
	begin
		$error("pc moved while done was high");
		assert_fails++;
	end

	// x0 always reads zero
	x0_zero: assert property (@(posedge clk) (dbg_addr == '0) |-> (dbg_data == '0))
	else
	begin
		$error("debug read of x0 was nonzero");
		assert_fails++;
	end

endmodule

bind rv_core rv_core_assert i_rv_core_assert (.clk(clk), .rst(rst), .done(done), .pc(pc),
	.dbg_addr(dbg_addr), .dbg_data(dbg_data));

`default_nettype wire

// File: src/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

// rv32i integer core, top level
module rv_core (
	input wire logic clk,
	input wire logic rst,
	// start/done handshake
	input wire logic start,
	output logic done,
	// program load
	input wire logic prog_we,
	input rv_core_pkg::pc_t prog_addr,
	input rv_core_pkg::word_t prog_data,
	// debug view
	input rv_core_pkg::reg_idx_t dbg_addr,
	output rv_core_pkg::word_t dbg_data,
	output rv_core_pkg::pc_t pc
);

	rv_core_pkg::pc_t imem_addr;
	rv_core_pkg::word_t imem_data;
	rv_core_pkg::reg_idx_t rs1;
	rv_core_pkg::reg_idx_t rs2;
	rv_core_pkg::word_t rs1_data;
	rv_core_pkg::word_t rs2_data;
	rv_core_pkg::alu_op_e alu_op;
	rv_core_pkg::word_t alu_a;
	rv_core_pkg::word_t alu_b;
	rv_core_pkg::word_t alu_y;
	rv_core_pkg::rf_wr_t wr;

	// --------------------------------------------------
	// blocks
	// --------------------------------------------------
	instr_mem i_instr_mem (.clk(clk), .addr(imem_addr), .rdata(imem_data),
		.we(prog_we), .waddr(prog_addr), .wdata(prog_data));

	core_ctrl i_core_ctrl (.clk(clk), .rst(rst), .start(start), .done(done), .pc(pc),
		.imem_addr(imem_addr), .imem_data(imem_data),
		.rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_y(alu_y), .wr(wr));

	// debug port bypasses the controller
	reg_file i_reg_file (.clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .wr(wr),
		.dbg_addr(dbg_addr), .dbg_data(dbg_data));

	alu i_alu (.op(alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

endmodule

`default_nettype wire

// File: src/core_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

// multicycle sequencer, 6 cycles per instruction
module core_ctrl (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	output logic done,
	output rv_core_pkg::pc_t pc,
	// instruction memory
	output rv_core_pkg::pc_t imem_addr,
	input rv_core_pkg::word_t imem_data,
	// register file
	output rv_core_pkg::reg_idx_t rs1,
	output rv_core_pkg::reg_idx_t rs2,
	input rv_core_pkg::word_t rs1_data,
	input rv_core_pkg::word_t rs2_data,
	// alu
	output rv_core_pkg::alu_op_e alu_op,
	output rv_core_pkg::word_t alu_a,
	output rv_core_pkg::word_t alu_b,
	input rv_core_pkg::word_t alu_y,
	output rv_core_pkg::rf_wr_t wr
);

	typedef enum logic [2:0] {
		st_idle, st_fetch, st_load, st_decode,
		st_operand, st_execute, st_writeback, st_halt
	} state_e;

	state_e state;
	state_e state_next;
	rv_core_pkg::instr_u instr;
	rv_core_pkg::dec_op_t dec;
	rv_core_pkg::dec_op_t dec_next;
	rv_core_pkg::word_t op_a;
	rv_core_pkg::word_t op_b;
	logic halt_hit;

	// funct3 to alu op, alt picks sub or sra
	function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] funct3, input logic alt);
		rv_core_pkg::alu_op_e sel;
		case (funct3)
			3'b000: sel = alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
			3'b001: sel = rv_core_pkg::alu_sll;
			3'b010: sel = rv_core_pkg::alu_slt;
			3'b011: sel = rv_core_pkg::alu_sltu;
			3'b100: sel = rv_core_pkg::alu_xor;
			3'b101: sel = alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
			3'b110: sel = rv_core_pkg::alu_or;
			default: sel = rv_core_pkg::alu_and;
		endcase
		return sel;
	endfunction

	// --------------------------------------------------
	// decode
	// --------------------------------------------------
	always_comb
	begin
		dec_next = '0;
		dec_next.rd = instr.r.rd;
		dec_next.rs1 = instr.r.rs1;
		dec_next.rs2 = instr.r.rs2;
		// 12-bit immediate, sign extended
		dec_next.imm = {{(rv_core_pkg::XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
		if (instr.r.opcode == rv_core_pkg::OPC_OP)
		begin
			dec_next.valid = 1'b1;
			dec_next.op = alu_sel(instr.r.funct3, instr.r.funct7[5]);
		end
		else if (instr.i.opcode == rv_core_pkg::OPC_OP_IMM)
		begin
			dec_next.valid = 1'b1;
			dec_next.use_imm = 1'b1;
			// addi has no sub form, only srai uses the alt bit
			dec_next.op = alu_sel(instr.i.funct3,
				(instr.i.funct3 == 3'b101) && instr.i.imm12[10]);
		end
	end

	// zero word ends the program
	assign halt_hit = (state == st_decode) && (instr == '0);

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle: if (start) state_next = st_fetch;
			st_fetch: state_next = st_load;
			st_load: state_next = st_decode;
			st_decode: state_next = halt_hit ? st_halt : st_operand;
			st_operand: state_next = st_execute;
			st_execute: state_next = st_writeback;
			st_writeback: state_next = st_fetch;
			st_halt: state_next = st_halt;
		endcase
	end

	// --------------------------------------------------
	// control state
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= st_idle;
			pc <= '0;
			done <= 1'b0;
			wr <= '0;
		end
		else
		begin
			state <= state_next;
			if (halt_hit)
				done <= 1'b1;
			// result lands in the write bundle, en only for known opcodes
			if (state == st_execute)
			begin
				wr.en <= dec.valid;
				wr.addr <= dec.rd;
				wr.data <= alu_y;
			end
			// write and pc step share the edge leaving writeback
			if (state == st_writeback)
			begin
				wr.en <= 1'b0;
				pc <= pc + 1'b1;
			end
		end
	end

	// datapath registers
	always_ff @(posedge clk)
	begin
		if (state == st_load)
			instr <= imem_data;
		if (state == st_decode)
			dec <= dec_next;
		if (state == st_operand)
		begin
			op_a <= rs1_data;
			op_b <= dec.use_imm ? dec.imm : rs2_data;
		end
	end

	assign imem_addr = pc;
	assign rs1 = dec.rs1;
	assign rs2 = dec.rs2;
	assign alu_op = dec.op;
	assign alu_a = op_a;
	assign alu_b = op_b;

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ns
`default_nettype none

// integer alu for op and op-imm
module alu (
	input rv_core_pkg::alu_op_e op,
	input rv_core_pkg::word_t a,
	input rv_core_pkg::word_t b,
	output rv_core_pkg::word_t y
);

	// shift amount from low bits of b
	logic [4:0] shamt;
	// compare results
	logic lt_s;
	logic lt_u;

	assign shamt = b[4:0];
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	// --------------------------------------------------
	// result select
	// --------------------------------------------------
	always_comb
	begin
		case (op)
			rv_core_pkg::alu_add:
				y = a + b;
			// wraps on underflow
			rv_core_pkg::alu_sub:
				y = a - b;
			rv_core_pkg::alu_sll:
				y = a << shamt;
			rv_core_pkg::alu_slt:
				y = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_s};
			rv_core_pkg::alu_sltu:
				y = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_u};
			rv_core_pkg::alu_xor:
				y = a ^ b;
			rv_core_pkg::alu_srl:
				y = a >> shamt;
			// arithmetic, sign bit fills from the left
			rv_core_pkg::alu_sra:
				y = $signed(a) >>> shamt;
			rv_core_pkg::alu_or:
				y = a | b;
			rv_core_pkg::alu_and:
				y = a & b;
			default:
				y = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

// x1..x31 in flops, x0 reads as zero
module reg_file (
	input wire logic clk,
	input wire logic rst,
	// operand read ports
	input rv_core_pkg::reg_idx_t rs1,
	input rv_core_pkg::reg_idx_t rs2,
	output rv_core_pkg::word_t rs1_data,
	output rv_core_pkg::word_t rs2_data,
	// writeback
	input rv_core_pkg::rf_wr_t wr,
	// debug read port
	input rv_core_pkg::reg_idx_t dbg_addr,
	output rv_core_pkg::word_t dbg_data
);

	// no storage behind x0
	rv_core_pkg::word_t regs [1:31];

	// --------------------------------------------------
	// write port
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 1; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr.en && (wr.addr != '0))
		begin
			// x0 writes never get this far
			regs[wr.addr] <= wr.data;
		end
	end

	// combinational reads, zero for x0
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];
	assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

`default_nettype wire

// File: src/instr_mem.sv
`timescale 1ns/1ns
`default_nettype none

// instruction store, one word per pc value
module instr_mem (
	input wire logic clk,
	// fetch side
	input rv_core_pkg::pc_t addr,
	output rv_core_pkg::word_t rdata,
	// program load side
	input wire logic we,
	input rv_core_pkg::pc_t waddr,
	input rv_core_pkg::word_t wdata
);

	// word array, no reset
	rv_core_pkg::word_t mem [rv_core_pkg::IMEM_DEPTH];

	// --------------------------------------------------
	// block ram style access
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		// load port, only used before start
		if (we)
		begin
			mem[waddr] <= wdata;
		end
		// registered read, data valid one cycle after addr
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// File: src/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

	// --------------------------------------------------
	// widths and sizes
	// --------------------------------------------------

	// data word
	localparam int XLEN = 32;
	// register index
	localparam int REG_AW = 5;
	// pc is a word address into instruction memory
	localparam int PC_W = 8;
	localparam int IMEM_DEPTH = 256;

	// major opcodes handled by the core
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_AW-1:0] reg_idx_t;
	typedef logic [PC_W-1:0] pc_t;

	// --------------------------------------------------
	// alu operations
	// --------------------------------------------------
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	// --------------------------------------------------
	// instruction formats
	// --------------------------------------------------

	// register-register layout
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t rs2;
		reg_idx_t rs1;
		logic [2:0] funct3;
		reg_idx_t rd;
		logic [6:0] opcode;
	} r_fmt_t;

	// register-immediate layout, imm12 overlays funct7 and rs2
	typedef struct packed {
		logic [11:0] imm12;
		reg_idx_t rs1;
		logic [2:0] funct3;
		reg_idx_t rd;
		logic [6:0] opcode;
	} i_fmt_t;

	// same 32 bits, two views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

	// decoded instruction, held from decode through writeback
	typedef struct packed {
		logic valid;
		logic use_imm;
		alu_op_e op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t imm;
	} dec_op_t;

	// one register file write
	typedef struct packed {
		logic en;
		reg_idx_t addr;
		word_t data;
	} rf_wr_t;

endpackage

`default_nettype wire
